/* pipePkg.sv */
/*
 * Instruction set definitions for the five-stage integer pipeline.
 * Holds the opcode type, field positions, adder constants and the
 * small decode helpers that every stage shares.
 */
package pipePkg;

  typedef enum logic [2:0] {NOP, MOV, SUB3, ADD4, ADD1} opcodeT;
  typedef logic [3:0]  regIdxT;
  typedef logic [15:0] dataT;
  typedef logic [31:0] instrT;

  // One-hot opcode bits at the top of the instruction word
  localparam int movBit  = 31;
  localparam int sub3Bit = 30;
  localparam int add4Bit = 29;
  localparam int add1Bit = 28;

  // Register fields in the low byte
  localparam int destMsb = 7;
  localparam int destLsb = 4;
  localparam int srcMsb  = 3;
  localparam int srcLsb  = 0;

  localparam dataT subAmount = 16'd3;
  localparam dataT addAmount = 16'd4;

  // Exactly one opcode bit must be set, anything else is a NOP
  function automatic opcodeT decodeOp(instrT instr);
    logic [3:0] opField;
    opcodeT op;
    opField = {instr[movBit], instr[sub3Bit], instr[add4Bit], instr[add1Bit]};
    case (opField)
      4'b1000: op = MOV;
      4'b0100: op = SUB3;
      4'b0010: op = ADD4;
      4'b0001: op = ADD1;
      default: op = NOP;
    endcase
    return op;
  endfunction

  // Opcodes that go through the subtract-3 adder in EX1
  function automatic logic usesSub(opcodeT op);
    return (op == SUB3) || (op == ADD1);
  endfunction

  // Opcodes that go through the add-4 adder in EX2
  function automatic logic usesAdd(opcodeT op);
    return (op == ADD4) || (op == ADD1);
  endfunction

endpackage

/* pipeStageIf.sv */
/*
 * Stage register bundle between two pipeline stages.
 * Carries the opcode, destination, operand value and the two
 * source-match flags computed in decode.
 */
interface pipeStageIf;
  import pipePkg::*;

  opcodeT op;
  regIdxT dest;
  dataT   data;

  // Source matched the destination of the instruction one stage ahead
  logic   matchEx1;

  // Source matched the destination of the instruction two stages ahead
  logic   matchEx2;

  // The producing stage owns every field of its register
  modport stage (
    output op, dest, data, matchEx1, matchEx2
  );

  // The consuming stage only looks at the register
  modport next (
    input op, dest, data, matchEx1, matchEx2
  );

endinterface

/* instrFetch.sv */
/*
 * Fetch stage with the program counter and instruction memory.
 * The memory is filled through the program-load port, and the fetched
 * word is held in the fetch/decode register while decode stalls.
 */
module instrFetch #(
  parameter int imemAddrBits = 6
) (
  input  logic                    CLK,
  input  logic                    RSTB,
  input  logic                    progWe,
  input  logic [imemAddrBits-1:0] progAddr,
  input  pipePkg::instrT          progData,
  input  logic                    stall,
  output pipePkg::instrT          idInstr
);
  import pipePkg::*;

  localparam int imemDepth = 1 << imemAddrBits;

  logic [7:0] pc;
  instrT      imem [0:imemDepth-1];
  instrT      fetchWord;

  // Program load, normally done while the core is held in reset
  always_ff @(posedge CLK)
  begin
    if (progWe)
    begin
      imem[progAddr] <= progData;
    end
  end

  // The low PC bits index the memory so the 8-bit PC wraps through it
  assign fetchWord = imem[pc[imemAddrBits-1:0]];

  // ------------------------------------------------------------------
  // PC and fetch/decode register, both frozen during a stall
  // ------------------------------------------------------------------
  always_ff @(posedge CLK or negedge RSTB)
  begin
    if (!RSTB)
    begin
      pc      <= '0;
      // An all-zero word has no opcode bit set and decodes as a NOP
      idInstr <= '0;
    end
    else if (!stall)
    begin
      pc      <= pc + 8'd1;
      idInstr <= fetchWord;
    end
  end

endmodule

/* regFile.sv */
/*
 * Sixteen 16-bit registers with one write port from write-back
 * and one combinational read port for decode, with a write bypass.
 */
module regFile (
  input  logic            CLK,
  input  logic            RSTB,
  input  logic            wbWrite,
  input  pipePkg::regIdxT wbReg,
  input  pipePkg::dataT   wbData,
  input  pipePkg::regIdxT readReg,
  output pipePkg::dataT   readData
);
  import pipePkg::*;

  dataT regs [0:15];

  // All registers clear to zero on reset
  always_ff @(posedge CLK or negedge RSTB)
  begin
    if (!RSTB)
    begin
      for (int i = 0; i < 16; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (wbWrite)
    begin
      regs[wbReg] <= wbData;
    end
  end

  // A read of the register being written this cycle sees the new value,
  // which covers a producer three instructions ahead of the reader
  always_comb
  begin
    if (wbWrite && (wbReg == readReg))
      readData = wbData;
    else
      readData = regs[readReg];
  end

endmodule

/* decodeStage.sv */
/*
 * Decode stage with the hazard compare station and stall logic.
 * Reads the source register and loads the decode/EX1 register,
 * putting a bubble into EX1 while the decode instruction waits.
 */
module decodeStage (
  input  logic            CLK,
  input  logic            RSTB,
  input  pipePkg::instrT  idInstr,
  input  pipePkg::regIdxT ex2Dest,
  output logic            stall,
  output pipePkg::regIdxT srcReg,
  input  pipePkg::dataT   srcData,
  pipeStageIf.stage       idEx1
);
  import pipePkg::*;

  opcodeT idOp;
  regIdxT idDest;
  logic   idMatchEx1;
  logic   idMatchEx2;

  // Local copy of the decode/EX1 register, also needed by the hazard check
  opcodeT ex1Op;
  regIdxT ex1Dest;
  dataT   ex1Data;
  logic   ex1MatchEx1;
  logic   ex1MatchEx2;

  // ------------------------------------------------------------------
  // Field decode and compare station
  // ------------------------------------------------------------------
  assign idOp   = decodeOp(idInstr);
  assign idDest = idInstr[destMsb:destLsb];
  assign srcReg = idInstr[srcMsb:srcLsb];

  assign idMatchEx1 = (srcReg == ex1Dest);
  assign idMatchEx2 = (srcReg == ex2Dest);

  // A subtracting instruction needs its operand at the start of EX1, but an
  // adding producer in EX1 only has its result at the end of EX2
  assign stall = usesSub(idOp) && idMatchEx1 && usesAdd(ex1Op);

  // ------------------------------------------------------------------
  // Decode/EX1 register
  // ------------------------------------------------------------------
  always_ff @(posedge CLK or negedge RSTB)
  begin
    if (!RSTB)
      ex1Op <= NOP;
    else if (stall)
      ex1Op <= NOP;
    else
      ex1Op <= idOp;
  end

  // The payload moves every cycle, stalled or not
  always_ff @(posedge CLK)
  begin
    ex1Dest     <= idDest;
    ex1Data     <= srcData;
    ex1MatchEx1 <= idMatchEx1;
    ex1MatchEx2 <= idMatchEx2;
  end

  assign idEx1.op       = ex1Op;
  assign idEx1.dest     = ex1Dest;
  assign idEx1.data     = ex1Data;
  assign idEx1.matchEx1 = ex1MatchEx1;
  assign idEx1.matchEx2 = ex1MatchEx2;

  // A held word stays in decode for exactly one extra cycle
  stallOneCycle: assert property (
    @(posedge CLK) disable iff (!RSTB) stall |=> !stall && $stable(idInstr)
  );

endmodule

/* subStage.sv */
/*
 * EX1 stage with operand forwarding and the subtract-3 adder.
 * Loads the EX1/EX2 register with the skipped or subtracted value.
 */
module subStage (
  input  logic          CLK,
  input  logic          RSTB,
  pipeStageIf.next      idEx1,
  pipeStageIf.stage     ex1Ex2,
  input  pipePkg::dataT ex2Value,
  input  logic          wbWrite,
  input  pipePkg::dataT wbData
);
  import pipePkg::*;

  logic   fwdFromEx2;
  logic   fwdFromWb;
  dataT   adderIn;
  dataT   ex1Result;

  opcodeT ex2Op;
  regIdxT ex2Dest;
  dataT   ex2Data;
  logic   ex2MatchEx1;

  // ------------------------------------------------------------------
  // Operand forwarding, the younger EX2 value wins over write-back
  // ------------------------------------------------------------------
  // Only MOV and SUB3 have their final value at the start of EX2
  assign fwdFromEx2 = idEx1.matchEx1 && ((ex2Op == SUB3) || (ex2Op == MOV));
  assign fwdFromWb  = idEx1.matchEx2 && wbWrite;

  always_comb
  begin
    if (fwdFromEx2)
      adderIn = ex2Value;
    else if (fwdFromWb)
      adderIn = wbData;
    else
      adderIn = idEx1.data;
  end

  // MOV and ADD4 skip the subtractor
  assign ex1Result = usesSub(idEx1.op) ? adderIn - subAmount : adderIn;

  // EX1/EX2 register
  always_ff @(posedge CLK or negedge RSTB)
  begin
    if (!RSTB)
      ex2Op <= NOP;
    else
      ex2Op <= idEx1.op;
  end

  always_ff @(posedge CLK)
  begin
    ex2Dest     <= idEx1.dest;
    ex2Data     <= ex1Result;
    ex2MatchEx1 <= idEx1.matchEx1;
  end

  assign ex1Ex2.op       = ex2Op;
  assign ex1Ex2.dest     = ex2Dest;
  assign ex1Ex2.data     = ex2Data;
  assign ex1Ex2.matchEx1 = ex2MatchEx1;

  // Decode must have stalled any subtracting consumer of an adding producer
  noLateProducer: assert property (
    @(posedge CLK) disable iff (!RSTB)
      !(idEx1.matchEx1 && usesSub(idEx1.op) && usesAdd(ex2Op))
  );

endmodule

/* addStage.sv */
/*
 * EX2 stage with write-back forwarding and the add-4 adder.
 * Registers the final result into the write-back register.
 */
module addStage (
  input  logic            CLK,
  input  logic            RSTB,
  pipeStageIf.next        ex1Ex2,
  output pipePkg::dataT   ex2Value,
  output logic            wbWrite,
  output pipePkg::regIdxT wbReg,
  output pipePkg::dataT   wbData
);
  import pipePkg::*;

  logic fwdFromWb;
  dataT ex2Result;

  // ------------------------------------------------------------------
  // Late forwarding for instructions that only need the operand here
  // ------------------------------------------------------------------
  // matchEx1 was taken in decode, so the producer it names now sits in
  // write-back
  assign fwdFromWb = ex1Ex2.matchEx1 && wbWrite &&
                     ((ex1Ex2.op == ADD4) || (ex1Ex2.op == MOV));

  // This value also feeds EX1, so a MOV helped here passes the fix along
  assign ex2Value = fwdFromWb ? wbData : ex1Ex2.data;

  assign ex2Result = usesAdd(ex1Ex2.op) ? ex2Value + addAmount : ex2Value;

  // EX2/write-back register
  always_ff @(posedge CLK or negedge RSTB)
  begin
    if (!RSTB)
      wbWrite <= 1'b0;
    else
      wbWrite <= (ex1Ex2.op != NOP);
  end

  always_ff @(posedge CLK)
  begin
    wbReg  <= ex1Ex2.dest;
    wbData <= ex2Result;
  end

  // The write strobe goes to the register file and both forwarding paths,
  // and a write must carry a known register and value
  wbWriteKnown: assert property (
    @(posedge CLK) disable iff (!RSTB)
      !$isunknown(wbWrite) && (!wbWrite || !$isunknown({wbReg, wbData}))
  );

endmodule

/* pipeCore.sv */
/*
 * Top level of the five-stage pipeline.
 * Connects fetch, decode, EX1, EX2, the register file and the two
 * stage register bundles, and exposes the write-back port.
 */
module pipeCore #(
  parameter int imemAddrBits = 6
) (
  input  logic                    CLK,
  input  logic                    RSTB,
  input  logic                    progWe,
  input  logic [imemAddrBits-1:0] progAddr,
  input  pipePkg::instrT          progData,
  output logic                    wbWrite,
  output pipePkg::regIdxT         wbReg,
  output pipePkg::dataT           wbData,
  output logic                    stall
);
  import pipePkg::*;

  instrT  idInstr;
  regIdxT srcReg;
  dataT   srcData;
  dataT   ex2Value;

  pipeStageIf idEx1 ();
  pipeStageIf ex1Ex2 ();

  instrFetch #(
    .imemAddrBits(imemAddrBits)
  ) u_instrFetch (
    .CLK(CLK), .RSTB(RSTB), .progWe(progWe), .progAddr(progAddr),
    .progData(progData), .stall(stall), .idInstr(idInstr)
  );

  regFile u_regFile (
    .CLK(CLK), .RSTB(RSTB), .wbWrite(wbWrite), .wbReg(wbReg),
    .wbData(wbData), .readReg(srcReg), .readData(srcData)
  );

  // Decode compares against the EX2 destination for write-back forwarding
  decodeStage u_decodeStage (
    .CLK(CLK), .RSTB(RSTB), .idInstr(idInstr), .ex2Dest(ex1Ex2.dest),
    .stall(stall), .srcReg(srcReg), .srcData(srcData), .idEx1(idEx1.stage)
  );

  subStage u_subStage (
    .CLK(CLK), .RSTB(RSTB), .idEx1(idEx1.next), .ex1Ex2(ex1Ex2.stage),
    .ex2Value(ex2Value), .wbWrite(wbWrite), .wbData(wbData)
  );

  addStage u_addStage (
    .CLK(CLK), .RSTB(RSTB), .ex1Ex2(ex1Ex2.next), .ex2Value(ex2Value),
    .wbWrite(wbWrite), .wbReg(wbReg), .wbData(wbData)
  );

endmodule

/* tbClock.sv */
/*
 * Testbench clock and reset generator.
 * Holds reset while the program loads, then for a few more cycles.
 */
module tbClock #(
  parameter int period      = 8,
  parameter int resetCycles = 5
) (
  input  logic hold,
  output logic CLK,
  output logic RSTB
);
  timeunit 1ns;
  timeprecision 100ps;

  initial
  begin
    CLK = 1'b0;
    forever #(period / 2) CLK = ~CLK;
  end

  // Reset leaves a small delay after the edge, like every other input
  initial
  begin
    RSTB = 1'b0;
    @(posedge CLK);
    wait (hold === 1'b0);
    repeat (resetCycles) @(posedge CLK);
    #1;
    RSTB = 1'b1;
  end

endmodule

/* tbPipeCore.sv */
/*
 * Testbench for the five-stage pipeline.
 * Loads a directed and a random program, runs a reference model of
 * the instruction set and compares every write-back and the stalls.
 */
module tbPipeCore;
  timeunit 1ns;
  timeprecision 100ps;
  import pipePkg::*;

  localparam int progWords  = 56;
  localparam int imemWords  = 64;
  localparam int tailCycles = 4;
  // Load, reset, one stall per word at most, pipeline depth plus tail, margin
  localparam int timeoutCycles = imemWords + 5 + 2 * progWords + 8 + 16;

  logic    CLK;
  logic    RSTB;
  logic    loading;
  logic    progWe;
  logic [5:0] progAddr;
  instrT   progData;
  logic    wbWrite;
  regIdxT  wbReg;
  dataT    wbData;
  logic    stall;

  instrT   prog [$];
  regIdxT  expReg [$];
  dataT    expData [$];
  int      expStalls;
  int      seenStalls;
  int      cycleCount = 0;
  integer  seed = 32'h1f6b;

  tbClock #(.period(8), .resetCycles(5)) u_tbClock (
    .hold(loading), .CLK(CLK), .RSTB(RSTB)
  );

  pipeCore #(.imemAddrBits(6)) u_pipeCore (
    .CLK(CLK), .RSTB(RSTB), .progWe(progWe), .progAddr(progAddr),
    .progData(progData), .wbWrite(wbWrite), .wbReg(wbReg),
    .wbData(wbData), .stall(stall)
  );

  // ------------------------------------------------------------------
  // Program builder
  // ------------------------------------------------------------------
  function automatic instrT encodeInstr(opcodeT op, regIdxT dest, regIdxT src);
    instrT word;
    word = {24'h0, dest, src};
    case (op)
      MOV:     word[31] = 1'b1;
      SUB3:    word[30] = 1'b1;
      ADD4:    word[29] = 1'b1;
      ADD1:    word[28] = 1'b1;
      default: word = {24'h0, dest, src};
    endcase
    return word;
  endfunction

  task automatic addInstr(opcodeT op, regIdxT dest, regIdxT src);
    prog.push_back(encodeInstr(op, dest, src));
  endtask

  task automatic buildProgram();
    int opSel;
    // Every opcode on registers nobody has written yet
    addInstr(MOV, 4'd1, 4'd0);
    addInstr(SUB3, 4'd2, 4'd0);
    addInstr(ADD4, 4'd3, 4'd0);
    addInstr(ADD1, 4'd4, 4'd0);
    // Two opcode bits set, so this word must not write
    prog.push_back(32'hC000_0021);
    // Consumers right behind SUB3 and MOV producers
    addInstr(SUB3, 4'd5, 4'd3);
    addInstr(SUB3, 4'd6, 4'd5);
    addInstr(MOV, 4'd7, 4'd6);
    addInstr(ADD4, 4'd8, 4'd7);
    // r9 is written one and two ahead of its reader, the nearer one counts
    addInstr(SUB3, 4'd9, 4'd4);
    addInstr(SUB3, 4'd9, 4'd9);
    addInstr(SUB3, 4'd10, 4'd9);
    // Subtracting readers of adding producers stall, the others do not
    addInstr(ADD4, 4'd11, 4'd8);
    addInstr(SUB3, 4'd12, 4'd11);
    addInstr(ADD1, 4'd13, 4'd12);
    addInstr(ADD1, 4'd13, 4'd13);
    addInstr(ADD4, 4'd14, 4'd13);
    addInstr(MOV, 4'd15, 4'd14);
    addInstr(ADD1, 4'd1, 4'd15);
    addInstr(ADD4, 4'd2, 4'd1);
    // Producers two and three words ahead of the reader
    addInstr(SUB3, 4'd5, 4'd2);
    addInstr(MOV, 4'd6, 4'd0);
    addInstr(ADD4, 4'd7, 4'd5);
    addInstr(ADD4, 4'd8, 4'd7);
    addInstr(MOV, 4'd9, 4'd0);
    addInstr(ADD1, 4'd10, 4'd8);
    addInstr(SUB3, 4'd11, 4'd10);
    addInstr(MOV, 4'd12, 4'd0);
    addInstr(MOV, 4'd13, 4'd0);
    addInstr(ADD4, 4'd14, 4'd11);
    while (prog.size() < progWords - 16)
      prog.push_back('0);
    // Random block on r0..r3 so that hazards are frequent
    for (int i = 0; i < 16; i++)
    begin
      opSel = $unsigned($random(seed)) % 5;
      addInstr(opcodeT'(opSel), regIdxT'($unsigned($random(seed)) % 4),
               regIdxT'($unsigned($random(seed)) % 4));
    end
  endtask

  // ------------------------------------------------------------------
  // Reference model, run in program order
  // ------------------------------------------------------------------
  function automatic opcodeT refOp(instrT word);
    if ($countones(word[31:28]) != 1)
      return NOP;
    if (word[31])
      return MOV;
    if (word[30])
      return SUB3;
    if (word[29])
      return ADD4;
    return ADD1;
  endfunction

  function automatic void buildExpected();
    dataT   model [0:15];
    opcodeT op;
    opcodeT prevOp;
    regIdxT prevDest;
    regIdxT dest;
    regIdxT src;
    dataT   value;
    for (int r = 0; r < 16; r++)
      model[r] = '0;
    prevOp    = NOP;
    prevDest  = '0;
    expStalls = 0;
    for (int i = 0; i < progWords; i++)
    begin
      op    = refOp(prog[i]);
      dest  = prog[i][7:4];
      src   = prog[i][3:0];
      value = model[src];
      if ((op == SUB3) || (op == ADD1))
        value = value - 16'd3;
      if ((op == ADD4) || (op == ADD1))
        value = value + 16'd4;
      if (op != NOP)
      begin
        model[dest] = value;
        expReg.push_back(dest);
        expData.push_back(value);
      end
      // One bubble whenever a subtracting word reads the adding word before it
      if (((op == SUB3) || (op == ADD1)) && ((prevOp == ADD4) || (prevOp == ADD1))
          && (src == prevDest))
        expStalls++;
      prevOp   = op;
      prevDest = dest;
    end
  endfunction

  // ------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------
  task automatic stopOnError(string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic checkReg(string name, regIdxT got, regIdxT exp);
    if (got !== exp)
      stopOnError($sformatf("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp));
  endtask

  task automatic checkData(string name, dataT got, dataT exp);
    if (got !== exp)
      stopOnError($sformatf("Error at %0t: %s is %h, expected %h", $time, name, got, exp));
  endtask

  task automatic checkFlag(string name, logic got, logic exp);
    if (got !== exp)
      stopOnError($sformatf("Error at %0t: %s is %b, expected %b", $time, name, got, exp));
  endtask

  task automatic checkCount(string name, int got, int exp);
    if (got != exp)
      stopOnError($sformatf("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp));
  endtask

  // Program load, all 64 words while the core is held in reset
  initial
  begin
    loading  = 1'b1;
    progWe   = 1'b0;
    progAddr = '0;
    progData = '0;
    buildProgram();
    buildExpected();
    @(posedge CLK);
    for (int a = 0; a < imemWords; a++)
    begin
      #1;
      progWe   = 1'b1;
      progAddr = a[5:0];
      progData = (a < progWords) ? prog[a] : '0;
      @(posedge CLK);
    end
    #1;
    progWe  = 1'b0;
    loading = 1'b0;
  end

  // Outputs are sampled on the falling edge, half a cycle after they change
  initial
  begin
    int expIdx;
    int quietCycles;
    expIdx      = 0;
    quietCycles = 0;
    seenStalls  = 0;
    forever
    begin
      @(negedge CLK);
      if (!RSTB)
      begin
        checkFlag("wbWrite", wbWrite, 1'b0);
        checkFlag("stall", stall, 1'b0);
      end
      else
      begin
        if (stall)
          seenStalls++;
        if (expIdx == 0)
          checkFlag("stall", stall, 1'b0);
        if (wbWrite)
        begin
          if (expIdx >= expReg.size())
            stopOnError("A write-back came after the last expected result");
          checkReg("wbReg", wbReg, expReg[expIdx]);
          checkData("wbData", wbData, expData[expIdx]);
          expIdx++;
          // Every stall holds a writing word, so all of them come before the last write
          if (expIdx == expReg.size())
            checkCount("stall cycles", seenStalls, expStalls);
        end
        else if (expIdx == expReg.size())
        begin
          checkFlag("stall", stall, 1'b0);
          quietCycles++;
        end
        if (quietCycles == tailCycles)
        begin
          $display("sim passed");
          $finish;
        end
      end
    end
  end

  // Watchdog on the total run length
  always @(posedge CLK)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= timeoutCycles)
      stopOnError($sformatf("Timeout: run still going after %0d cycles", cycleCount));
  end

endmodule

/* tb.f */
pipePkg.sv
pipeStageIf.sv
instrFetch.sv
regFile.sv
decodeStage.sv
subStage.sv
addStage.sv
pipeCore.sv
tbClock.sv
tbPipeCore.sv

/* run.sh */
#!/bin/sh
# Compile and run the pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tbPipeCore -f tb.f -o simPipeCore
./obj_dir/simPipeCore
